//--- bench/udp_echo_stim.txt
# H ip src_port dst_port length beat_count   (hex fields, beat_count decimal)
# B data keep last user                      (hex fields, beats follow their header)
H c0a80a02 c350 04d2 001c 3
B 0001020304050607 ff 0 0
B 08090a0b0c0d0e0f ff 0 0
B 1011121314151617 0f 1 0
H c0a80a03 1f90 0035 0018 2
B a5a5a5a5a5a5a5a5 ff 0 0
B 5a5a5a5a5a5a5a5a ff 1 0
H c0a80a02 c351 04d2 0009 1
B deadbeefcafef00d 01 1 1
H 0a000001 2710 04d2 0026 4
B 1111111111111111 ff 0 0
B 2222222222222222 ff 0 0
B 3333333333333333 ff 0 0
B 4444444444444444 3f 1 0
H 0a000002 2711 04d3 0010 1
B 0123456789abcdef ff 1 0
H 0a000003 2712 04d2 0017 2
B fedcba9876543210 ff 0 0
B 0f1e2d3c4b5a6978 7f 1 1
H ac100005 ea60 04d2 0010 1
B 8877665544332211 ff 1 0

//--- tb.f
hdl/udp_echo_pkg.sv
hdl/udp_stream_if.sv
hdl/stream_fifo.sv
hdl/udp_echo_filter.sv
hdl/udp_echo_top.sv
bench/tb_udp_echo.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_udp_echo
FLIST := tb.f
OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ)

//--- bench/tb_udp_echo.sv
// UDP echo core testbench driving frames from a stimulus file and checking predicted replies
`timescale 1ns/10ps

module tb_udp_echo;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234;
    localparam int TIMEOUT = 2000;

    logic                                clk;
    logic                                rst;
    logic                                rx_hdr_valid;
    logic                                rx_hdr_ready;
    udp_echo_pkg::ip_addr_t              rx_ip;
    udp_echo_pkg::udp_port_t             rx_src_port;
    udp_echo_pkg::udp_port_t             rx_dst_port;
    logic [15:0]                         rx_length;
    logic [udp_echo_pkg::DATA_WIDTH-1:0] rx_tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] rx_tkeep;
    logic                                rx_tlast;
    logic                                rx_tuser;
    logic                                rx_tvalid;
    logic                                rx_tready;
    logic                                tx_hdr_valid;
    logic                                tx_hdr_ready;
    udp_echo_pkg::ip_addr_t              tx_ip;
    udp_echo_pkg::udp_port_t             tx_src_port;
    udp_echo_pkg::udp_port_t             tx_dst_port;
    logic [15:0]                         tx_length;
    logic [udp_echo_pkg::DATA_WIDTH-1:0] tx_tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] tx_tkeep;
    logic                                tx_tlast;
    logic                                tx_tuser;
    logic                                tx_tvalid;
    logic                                tx_tready;

    // Frames as read and replies as predicted
    udp_echo_pkg::udp_hdr_t frame_hdrs[$];
    int                     frame_beats[$];
    udp_echo_pkg::beat_t    stim_beats[$];
    udp_echo_pkg::udp_hdr_t exp_hdrs[$];
    udp_echo_pkg::beat_t    exp_beats[$];

    int     value_errors = 0;
    int     other_errors = 0;
    int     hdr_seen = 0;
    int     beat_seen = 0;
    bit     timed_out = 1'b0;
    integer seed = 32'hcae3151a;

    udp_echo_top UUT (
        .clk         (clk),
        .rst         (rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_ip       (rx_ip),
        .rx_src_port (rx_src_port),
        .rx_dst_port (rx_dst_port),
        .rx_length   (rx_length),
        .rx_tdata    (rx_tdata),
        .rx_tkeep    (rx_tkeep),
        .rx_tlast    (rx_tlast),
        .rx_tuser    (rx_tuser),
        .rx_tvalid   (rx_tvalid),
        .rx_tready   (rx_tready),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_ip       (tx_ip),
        .tx_src_port (tx_src_port),
        .tx_dst_port (tx_dst_port),
        .tx_length   (tx_length),
        .tx_tdata    (tx_tdata),
        .tx_tkeep    (tx_tkeep),
        .tx_tlast    (tx_tlast),
        .tx_tuser    (tx_tuser),
        .tx_tvalid   (tx_tvalid),
        .tx_tready   (tx_tready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random back-pressure on both reply outputs
    initial begin
        logic [31:0] r;
        logic        in_reset;
        tx_hdr_ready = 1'b0;
        tx_tready = 1'b0;
        forever begin
            @(posedge clk);
            in_reset = rst;
            #1;
            if (!in_reset) begin
                r = $random(seed);
                tx_hdr_ready = r[0] | r[1];
                tx_tready = r[2] | r[3];
            end
        end
    end

    task automatic load_stim(output bit ok);
        int                                  fd;
        int                                  n;
        int                                  nb;
        int                                  total_nb;
        bit                                  bad;
        bit                                  echo;
        string                               line;
        udp_echo_pkg::ip_addr_t              ip;
        udp_echo_pkg::udp_port_t             sp;
        udp_echo_pkg::udp_port_t             dp;
        logic [15:0]                         len;
        logic [udp_echo_pkg::DATA_WIDTH-1:0] d;
        logic [udp_echo_pkg::KEEP_WIDTH-1:0] k;
        logic                                l;
        logic                                u;
        udp_echo_pkg::udp_hdr_t              h;
        udp_echo_pkg::beat_t                 b;
        ok = 1'b0;
        bad = 1'b0;
        echo = 1'b0;
        total_nb = 0;
        fd = $fopen("bench/udp_echo_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/udp_echo_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "H") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %d",
                            ip, sp, dp, len, nb);
                bad = bad | (n != 5);
                h.ip = ip;
                h.src_port = sp;
                h.dst_port = dp;
                h.length = len;
                frame_hdrs.push_back(h);
                frame_beats.push_back(nb);
                total_nb += nb;
                // Reply swaps the ports and goes back to the sender
                echo = (dp == ECHO_PORT);
                if (echo) begin
                    h.src_port = dp;
                    h.dst_port = sp;
                    exp_hdrs.push_back(h);
                end
            end else if (line[0] == "B") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", d, k, l, u);
                bad = bad | (n != 4);
                b.data = d;
                b.keep = k;
                b.last = l;
                b.user = u;
                stim_beats.push_back(b);
                if (echo) begin
                    exp_beats.push_back(b);
                end
            end else begin
                bad = 1'b1;
            end
        end
        $fclose(fd);
        if (bad || total_nb != stim_beats.size() || frame_hdrs.size() == 0) begin
            $display("stimulus file is malformed");
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_hdr(input udp_echo_pkg::udp_hdr_t got,
                             input udp_echo_pkg::udp_hdr_t exp);
        if (got !== exp) begin
            $write("CHECK FAILED tx_hdr: got ip %h src %h dst %h len %h",
                   got.ip, got.src_port, got.dst_port, got.length);
            $display(" expected ip %h src %h dst %h len %h",
                     exp.ip, exp.src_port, exp.dst_port, exp.length);
            value_errors++;
        end
    endtask

    task automatic check_beat(input udp_echo_pkg::beat_t got, input udp_echo_pkg::beat_t exp);
        if (got !== exp) begin
            $write("CHECK FAILED tx_beat: got data %h keep %h last %h user %h",
                   got.data, got.keep, got.last, got.user);
            $display(" expected data %h keep %h last %h user %h",
                     exp.data, exp.keep, exp.last, exp.user);
            value_errors++;
        end
    endtask

    task automatic send_header(input udp_echo_pkg::udp_hdr_t h, input int idx);
        int n;
        bit took;
        rx_ip = h.ip;
        rx_src_port = h.src_port;
        rx_dst_port = h.dst_port;
        rx_length = h.length;
        rx_hdr_valid = 1'b1;
        n = 0;
        took = 1'b0;
        while (!took && n < TIMEOUT) begin
            @(posedge clk);
            took = rx_hdr_ready;
            n++;
        end
        #1 rx_hdr_valid = 1'b0;
        if (!took) begin
            $display("timeout: header of frame %0d was never accepted", idx);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_beat(input udp_echo_pkg::beat_t b, input int idx);
        int n;
        bit took;
        rx_tdata = b.data;
        rx_tkeep = b.keep;
        rx_tlast = b.last;
        rx_tuser = b.user;
        rx_tvalid = 1'b1;
        n = 0;
        took = 1'b0;
        while (!took && n < TIMEOUT) begin
            @(posedge clk);
            took = rx_tready;
            n++;
        end
        #1 rx_tvalid = 1'b0;
        if (!took) begin
            $display("timeout: payload of frame %0d was not consumed", idx);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    // Frames back to back with the next header right after the last beat
    task automatic drive_frames();
        int bi;
        bi = 0;
        for (int f = 0; f < frame_hdrs.size(); f++) begin
            if (timed_out) begin
                break;
            end
            send_header(frame_hdrs[f], f);
            for (int i = 0; i < frame_beats[f] && !timed_out; i++) begin
                send_beat(stim_beats[bi], f);
                bi++;
            end
        end
    endtask

    task automatic collect_hdrs();
        int                     idle;
        udp_echo_pkg::udp_hdr_t got;
        idle = 0;
        while (hdr_seen < exp_hdrs.size() && !timed_out) begin
            @(posedge clk);
            if (tx_hdr_valid && tx_hdr_ready) begin
                got.ip = tx_ip;
                got.src_port = tx_src_port;
                got.dst_port = tx_dst_port;
                got.length = tx_length;
                check_hdr(got, exp_hdrs[hdr_seen]);
                hdr_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= TIMEOUT) begin
                    $display("timeout: reply header %0d never arrived", hdr_seen);
                    other_errors++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic collect_beats();
        int                  idle;
        udp_echo_pkg::beat_t got;
        idle = 0;
        while (beat_seen < exp_beats.size() && !timed_out) begin
            @(posedge clk);
            if (tx_tvalid && tx_tready) begin
                got.data = tx_tdata;
                got.keep = tx_tkeep;
                got.last = tx_tlast;
                got.user = tx_tuser;
                check_beat(got, exp_beats[beat_seen]);
                beat_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= TIMEOUT) begin
                    $display("timeout: reply beat %0d never arrived", beat_seen);
                    other_errors++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    initial begin
        bit ok;
        rst = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_ip = '0;
        rx_src_port = '0;
        rx_dst_port = '0;
        rx_length = '0;
        rx_tdata = '0;
        rx_tkeep = '0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
        rx_tvalid = 1'b0;
        load_stim(ok);
        if (!ok) begin
            other_errors++;
        end else begin
            repeat (16) @(posedge clk);
            #1 rst = 1'b0;
            @(posedge clk);
            check_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
            check_flag("tx_tvalid", tx_tvalid, 1'b0);
            check_flag("rx_tready", rx_tready, 1'b0);
            check_flag("rx_hdr_ready", rx_hdr_ready, 1'b1);
            #1;
            fork
                drive_frames();
                collect_hdrs();
                collect_beats();
            join
            // Anything still offered now is an extra reply
            for (int i = 0; i < 50 && !timed_out; i++) begin
                @(posedge clk);
                if (tx_hdr_valid || tx_tvalid) begin
                    $display("reply output still valid after all expected replies");
                    other_errors++;
                    break;
                end
            end
        end
        $display("headers %0d/%0d, beats %0d/%0d, value errors %0d, other errors %0d",
                 hdr_seen, exp_hdrs.size(), beat_seen, exp_beats.size(),
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hdl/udp_echo_top.sv
// UDP echo core top level feeding the filter into reply header and payload queues
`timescale 1ns/10ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::ECHO_PORT_DEFAULT,
    parameter int HDR_DEPTH = udp_echo_pkg::HDR_DEPTH_DEFAULT,
    parameter int PAYLOAD_DEPTH = udp_echo_pkg::PAYLOAD_DEPTH_DEFAULT
) (
    input  logic                                clk,
    input  logic                                rst,

    // Received UDP header
    input  logic                                rx_hdr_valid,
    output logic                                rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t              rx_ip,
    input  udp_echo_pkg::udp_port_t             rx_src_port,
    input  udp_echo_pkg::udp_port_t             rx_dst_port,
    input  logic [15:0]                         rx_length,

    // Received payload
    input  logic [udp_echo_pkg::DATA_WIDTH-1:0] rx_tdata,
    input  logic [udp_echo_pkg::KEEP_WIDTH-1:0] rx_tkeep,
    input  logic                                rx_tlast,
    input  logic                                rx_tuser,
    input  logic                                rx_tvalid,
    output logic                                rx_tready,

    // Reply header
    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t              tx_ip,
    output udp_echo_pkg::udp_port_t             tx_src_port,
    output udp_echo_pkg::udp_port_t             tx_dst_port,
    output logic [15:0]                         tx_length,

    // Reply payload
    output logic [udp_echo_pkg::DATA_WIDTH-1:0] tx_tdata,
    output logic [udp_echo_pkg::KEEP_WIDTH-1:0] tx_tkeep,
    output logic                                tx_tlast,
    output logic                                tx_tuser,
    output logic                                tx_tvalid,
    input  logic                                tx_tready
);

    udp_echo_pkg::udp_hdr_t rx_hdr;
    udp_echo_pkg::udp_hdr_t reply_hdr;
    udp_echo_pkg::udp_hdr_t tx_hdr;
    udp_echo_pkg::beat_t    fwd_beat;
    udp_echo_pkg::beat_t    tx_beat;
    logic                   reply_valid;
    logic                   reply_ready;

    udp_stream_if rx_if ();
    udp_stream_if fwd_if ();

    assign rx_hdr = '{ip: rx_ip, src_port: rx_src_port, dst_port: rx_dst_port,
                      length: rx_length};

    assign rx_if.tdata  = rx_tdata;
    assign rx_if.tkeep  = rx_tkeep;
    assign rx_if.tlast  = rx_tlast;
    assign rx_if.tuser  = rx_tuser;
    assign rx_if.tvalid = rx_tvalid;
    assign rx_tready    = rx_if.tready;

    udp_echo_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) filter (
        .clk         (clk),
        .rst         (rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_hdr      (rx_hdr),
        .rx          (rx_if.sink),
        .fwd         (fwd_if.src),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready),
        .reply       (reply_hdr)
    );

    stream_fifo #(
        .T    (udp_echo_pkg::udp_hdr_t),
        .DEPTH(HDR_DEPTH)
    ) hdr_queue (
        .clk      (clk),
        .rst      (rst),
        .in_data  (reply_hdr),
        .in_valid (reply_valid),
        .in_ready (reply_ready),
        .out_data (tx_hdr),
        .out_valid(tx_hdr_valid),
        .out_ready(tx_hdr_ready)
    );

    assign tx_ip       = tx_hdr.ip;
    assign tx_src_port = tx_hdr.src_port;
    assign tx_dst_port = tx_hdr.dst_port;
    assign tx_length   = tx_hdr.length;

    // Forwarded beat stored whole
    assign fwd_beat = '{data: fwd_if.tdata, keep: fwd_if.tkeep, last: fwd_if.tlast,
                        user: fwd_if.tuser};

    stream_fifo #(
        .T    (udp_echo_pkg::beat_t),
        .DEPTH(PAYLOAD_DEPTH)
    ) payload_queue (
        .clk      (clk),
        .rst      (rst),
        .in_data  (fwd_beat),
        .in_valid (fwd_if.tvalid),
        .in_ready (fwd_if.tready),
        .out_data (tx_beat),
        .out_valid(tx_tvalid),
        .out_ready(tx_tready)
    );

    assign tx_tdata = tx_beat.data;
    assign tx_tkeep = tx_beat.keep;
    assign tx_tlast = tx_beat.last;
    assign tx_tuser = tx_beat.user;

endmodule

//--- hdl/udp_echo_filter.sv
// Echo port match, reply header rewrite and per-frame payload steering
`timescale 1ns/10ps

module udp_echo_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::ECHO_PORT_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,

    // Received header
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t rx_hdr,

    // Received payload and forwarded payload
    udp_stream_if.sink             rx,
    udp_stream_if.src              fwd,

    // Reply header to the header queue
    output logic                   reply_valid,
    input  logic                   reply_ready,
    output udp_echo_pkg::udp_hdr_t reply
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASS,
        ST_DROP
    } state_t;

    state_t state;
    logic   hdr_match;
    logic   hdr_accept;
    logic   beat_done;

    assign hdr_match = (rx_hdr.dst_port == ECHO_PORT);

    // Non-matching headers never wait on the header queue
    assign rx_hdr_ready = (state == ST_IDLE) && (!hdr_match || reply_ready);
    assign hdr_accept = rx_hdr_valid && rx_hdr_ready;

    assign reply_valid = (state == ST_IDLE) && rx_hdr_valid && hdr_match;

    // Ports swapped and reply sent back to the requester
    always_comb begin
        reply.ip       = rx_hdr.ip;
        reply.src_port = rx_hdr.dst_port;
        reply.dst_port = rx_hdr.src_port;
        reply.length   = rx_hdr.length;
    end

    // Beats pass straight through when echoed
    assign fwd.tdata  = rx.tdata;
    assign fwd.tkeep  = rx.tkeep;
    assign fwd.tlast  = rx.tlast;
    assign fwd.tuser  = rx.tuser;
    assign fwd.tvalid = rx.tvalid && (state == ST_PASS);

    always_comb begin
        case (state)
            ST_PASS: rx.tready = fwd.tready;
            // Discard at one beat per cycle
            ST_DROP: rx.tready = 1'b1;
            default: rx.tready = 1'b0;
        endcase
    end

    assign beat_done = rx.tvalid && rx.tready && rx.tlast;

    // Frame tracker
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_accept) begin
                        state <= hdr_match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (beat_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Tracker back in idle after the last beat takes no payload
    a_no_beat_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        beat_done |=> !rx.tready
    ) else $error("payload accepted with no frame open");

    // No reply offered right after a header opens its frame
    a_reply_only_idle: assert property (
        @(posedge clk) disable iff (rst)
        hdr_accept |=> !reply_valid
    ) else $error("reply offered while a frame is open");

endmodule

//--- hdl/stream_fifo.sv
// Valid/ready FIFO for any item type built as a circular buffer with occupancy count
`timescale 1ns/10ps

module stream_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,

    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH even when it is not a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH)
    ) else $error("fifo count above depth");

    // Popping the only item leaves nothing on offer
    a_empty_invalid: assert property (
        @(posedge clk) disable iff (rst)
        (count == CNT_W'(1)) && pop && !push |=> !out_valid
    ) else $error("fifo offers data while empty");

endmodule

//--- hdl/udp_stream_if.sv
// Payload stream bus with byte keep, last and bad-frame user flag
`timescale 1ns/10ps

interface udp_stream_if;

    logic [udp_echo_pkg::DATA_WIDTH-1:0] tdata;
    logic [udp_echo_pkg::KEEP_WIDTH-1:0] tkeep;
    logic                                tlast;
    logic                                tuser;
    logic                                tvalid;
    logic                                tready;

    modport src (
        output tdata,
        output tkeep,
        output tlast,
        output tuser,
        output tvalid,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tuser,
        input  tvalid,
        output tready
    );

endinterface

//--- hdl/udp_echo_pkg.sv
// UDP echo shared widths, header and beat types, default sizing
package udp_echo_pkg;

    // Payload bus
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // ip holds the sender on ingress and the reply destination on egress
    typedef struct packed {
        ip_addr_t  ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload beat as stored in the payload queue
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  user;
    } beat_t;

    // Port answered by the echo core
    localparam udp_port_t ECHO_PORT_DEFAULT = 16'd1234;

    // Queue depths
    localparam int HDR_DEPTH_DEFAULT = 4;
    localparam int PAYLOAD_DEPTH_DEFAULT = 64;

endpackage
